// ==== project.f ====
rename_pkg.sv
rename_map.sv
free_list.sv
rob.sv
rename_dispatch.sv
rename_core.sv
tb_rename_core.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rename core testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_rename_core -Mdir obj_dir

./obj_dir/Vtb_rename_core > sim.log 2>&1
cat sim.log

if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== tb_rename_core.sv ====
// testbench for rename core with clock, reset, stimulus, reference model and checking assertions
`timescale 1ns/1ps

module tb_rename_core;
	import rename_pkg::*;

	localparam int PREGS   = PREG_COUNT_DEF;
	localparam int DEPTH   = ROB_DEPTH_DEF;
	localparam int CREDITS = IQ_CREDITS_DEF;
	localparam int TAG_W   = $clog2(PREGS);
	localparam int IDX_W   = $clog2(DEPTH);
	localparam int LIMIT   = 200;  // cycles per wait

	logic             clk;
	logic             rst_i;
	logic             inst_valid_i;
	arch_reg_t        inst_dest_i;
	arch_reg_t        inst_src_a_i;
	arch_reg_t        inst_src_b_i;
	logic             inst_accept_o;
	logic             iq_credit_i;
	logic             iq_valid_o;
	logic [TAG_W-1:0] iq_dest_preg_o;
	logic [TAG_W-1:0] iq_old_preg_o;
	logic [TAG_W-1:0] iq_src_a_preg_o;
	logic             iq_src_a_rdy_o;
	logic [TAG_W-1:0] iq_src_b_preg_o;
	logic             iq_src_b_rdy_o;
	logic [IDX_W-1:0] iq_rob_idx_o;
	logic             complete_valid_i;
	logic [IDX_W-1:0] complete_rob_idx_i;
	logic [TAG_W-1:0] complete_preg_i;
	logic             retire_valid_o;
	arch_reg_t        retire_areg_o;
	logic [TAG_W-1:0] retire_preg_o;

	// reference model state
	logic [TAG_W-1:0] m_map [NUM_AREGS];
	logic [PREGS-1:0] m_ready;
	logic [TAG_W-1:0] m_free [$];        // free tags from the head on
	arch_reg_t        m_rob_areg [DEPTH];
	logic [TAG_W-1:0] m_rob_new [DEPTH];
	logic [TAG_W-1:0] m_rob_old [DEPTH];
	logic [DEPTH-1:0] m_rob_dest;
	logic [DEPTH-1:0] m_rob_done;
	int               m_head;
	int               m_tail;
	int               m_count;
	int               m_credits;
	int               m_nfree;
	int               m_accepts;         // accepted so far
	logic             m_push;            // old tag on its way back
	logic [TAG_W-1:0] m_push_tag;

	// expected DUT outputs
	logic             exp_accept;
	logic             exp_iq_valid;
	logic [TAG_W-1:0] exp_dest;
	logic [TAG_W-1:0] exp_old;
	logic [TAG_W-1:0] exp_src_a;
	logic [TAG_W-1:0] exp_src_b;
	logic [1:0]       exp_rdy;           // {a, b}
	logic [IDX_W-1:0] exp_idx;
	logic             exp_retire;
	arch_reg_t        exp_ret_areg;
	logic [TAG_W-1:0] exp_ret_preg;
	logic             auto_credit;       // iq hands slots straight back
	integer           seed;

	rename_core i_rename_core (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// reference model
	// ==============================
	assign exp_accept = inst_valid_i && (m_credits > 0) && (m_count < DEPTH) &&
		((m_nfree > 0) || (inst_dest_i == ZERO_REG));

	// same-cycle completion counts as ready
	function automatic logic fwd_ready(input logic [TAG_W-1:0] tag);
		return m_ready[tag] | (complete_valid_i && (complete_preg_i == tag));
	endfunction

	always @(posedge clk) begin : model
		logic             acc;
		logic             ret;
		logic [TAG_W-1:0] tnew;
		acc  = exp_accept;
		ret  = (m_count != 0) && m_rob_done[m_head];  // head done, leaves now
		tnew = (m_free.size() != 0) ? m_free[0] : '0;
		if (rst_i) begin
			for (int r = 0; r < NUM_AREGS; r++) begin
				m_map[r] = TAG_W'(r);
			end
			m_ready = '1;
			m_free.delete();
			for (int t = NUM_AREGS; t < PREGS; t++) begin
				m_free.push_back(TAG_W'(t));
			end
			m_rob_done   = '0;
			m_head       = 0;
			m_tail       = 0;
			m_count      = 0;
			m_credits    = CREDITS;
			m_push       = 1'b0;
			exp_iq_valid = 1'b0;
			exp_retire   = 1'b0;
		end else begin
			exp_iq_valid = acc;
			exp_retire   = ret;
			if (acc) begin
				exp_dest  = (inst_dest_i != ZERO_REG) ? tnew : '0;
				exp_old   = m_map[inst_dest_i];
				exp_src_a = m_map[inst_src_a_i];
				exp_src_b = m_map[inst_src_b_i];
				exp_rdy   = {fwd_ready(exp_src_a), fwd_ready(exp_src_b)};
				exp_idx   = IDX_W'(m_tail);
			end
			if (ret) begin
				exp_ret_areg = m_rob_areg[m_head];
				exp_ret_preg = m_rob_dest[m_head] ? m_rob_new[m_head] : '0;
			end
			if (acc && (inst_dest_i != ZERO_REG)) begin
				void'(m_free.pop_front());
				m_map[inst_dest_i] = tnew;
			end
			if (m_push) begin
				m_free.push_back(m_push_tag);  // poppable from next cycle
			end
			m_push     = ret && m_rob_dest[m_head];
			m_push_tag = m_rob_old[m_head];
			if (complete_valid_i) begin
				m_ready[complete_preg_i]       = 1'b1;
				m_rob_done[complete_rob_idx_i] = 1'b1;
			end
			if (acc) begin
				if (inst_dest_i != ZERO_REG) begin
					m_ready[tnew] = 1'b0;
				end
				m_rob_areg[m_tail] = inst_dest_i;
				m_rob_new[m_tail]  = tnew;
				m_rob_old[m_tail]  = exp_old;
				m_rob_dest[m_tail] = (inst_dest_i != ZERO_REG);
				m_rob_done[m_tail] = 1'b0;
				m_tail             = (m_tail + 1) % DEPTH;
				m_accepts++;
			end
			if (ret) begin
				m_head = (m_head + 1) % DEPTH;
			end
			m_count   = m_count + (acc ? 1 : 0) - (ret ? 1 : 0);
			m_credits = m_credits + (iq_credit_i ? 1 : 0) - (acc ? 1 : 0);
		end
		m_nfree = m_free.size();
	end

	// ==============================
	// checks
	// ==============================
	task automatic fail_run(input string what);
		$display("Something failed");
		$display("%s", what);
		$fatal(1, "testbench stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_run($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	a_accept: assert property (@(posedge clk) disable iff (rst_i) inst_accept_o == exp_accept)
		else report_mismatch("inst_accept_o", $sampled(inst_accept_o), $sampled(exp_accept));
	a_iq_valid: assert property (@(posedge clk) disable iff (rst_i) iq_valid_o == exp_iq_valid)
		else report_mismatch("iq_valid_o", $sampled(iq_valid_o), $sampled(exp_iq_valid));
	a_dest: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> iq_dest_preg_o == exp_dest)
		else report_mismatch("iq_dest_preg_o", $sampled(iq_dest_preg_o), $sampled(exp_dest));
	a_old: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> iq_old_preg_o == exp_old)
		else report_mismatch("iq_old_preg_o", $sampled(iq_old_preg_o), $sampled(exp_old));
	a_src_a: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> iq_src_a_preg_o == exp_src_a)
		else report_mismatch("iq_src_a_preg_o", $sampled(iq_src_a_preg_o), $sampled(exp_src_a));
	a_src_b: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> iq_src_b_preg_o == exp_src_b)
		else report_mismatch("iq_src_b_preg_o", $sampled(iq_src_b_preg_o), $sampled(exp_src_b));
	a_rdy: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> {iq_src_a_rdy_o, iq_src_b_rdy_o} == exp_rdy)
		else report_mismatch("iq_src_a_rdy_o/iq_src_b_rdy_o",
			$sampled({iq_src_a_rdy_o, iq_src_b_rdy_o}), $sampled(exp_rdy));
	a_rob_idx: assert property (@(posedge clk) disable iff (rst_i)
		exp_iq_valid |-> iq_rob_idx_o == exp_idx)
		else report_mismatch("iq_rob_idx_o", $sampled(iq_rob_idx_o), $sampled(exp_idx));
	a_retire: assert property (@(posedge clk) disable iff (rst_i) retire_valid_o == exp_retire)
		else report_mismatch("retire_valid_o", $sampled(retire_valid_o), $sampled(exp_retire));
	a_ret_areg: assert property (@(posedge clk) disable iff (rst_i)
		exp_retire |-> retire_areg_o == exp_ret_areg)
		else report_mismatch("retire_areg_o", $sampled(retire_areg_o), $sampled(exp_ret_areg));
	a_ret_preg: assert property (@(posedge clk) disable iff (rst_i)
		exp_retire |-> retire_preg_o == exp_ret_preg)
		else report_mismatch("retire_preg_o", $sampled(retire_preg_o), $sampled(exp_ret_preg));

	// ==============================
	// stimulus
	// ==============================
	function automatic arch_reg_t rand_areg();
		return arch_reg_t'($random(seed));
	endfunction

	task automatic step();
		@(negedge clk);
		complete_valid_i = 1'b0;                                 // completions last one cycle
		iq_credit_i      = auto_credit && (m_credits < CREDITS);  // never above the limit
	endtask

	task automatic issue(input arch_reg_t dest, input arch_reg_t src_a, input arch_reg_t src_b);
		int start;
		int n;
		start        = m_accepts;
		n            = 0;
		inst_valid_i = 1'b1;
		inst_dest_i  = dest;
		inst_src_a_i = src_a;
		inst_src_b_i = src_b;
		while (m_accepts == start) begin
			step();
			n++;
			if (n > LIMIT) begin
				fail_run("instruction was never accepted");
			end
		end
		inst_valid_i = 1'b0;
	endtask

	// valid stays high until the caller issues the same instruction
	task automatic expect_stall(input arch_reg_t dest, input arch_reg_t src_a,
		input arch_reg_t src_b, input int cycles);
		int start;
		start        = m_accepts;
		inst_valid_i = 1'b1;
		inst_dest_i  = dest;
		inst_src_a_i = src_a;
		inst_src_b_i = src_b;
		repeat (cycles) step();
		if (m_accepts != start) begin
			fail_run("instruction accepted during a stall");
		end
	endtask

	task automatic mark_complete(input int idx);
		complete_valid_i   = 1'b1;
		complete_rob_idx_i = IDX_W'(idx);
		complete_preg_i    = m_rob_dest[idx] ? m_rob_new[idx] : m_map[ZERO_REG];
	endtask

	task automatic complete_shuffled();
		int live [$];
		int idx;
		bit more;
		more = 1'b1;
		while (more) begin
			live.delete();
			for (int k = 0; k < m_count; k++) begin
				idx = (m_head + k) % DEPTH;
				if (!m_rob_done[idx]) begin
					live.push_back(idx);
				end
			end
			more = (live.size() != 0);
			if (more) begin
				mark_complete(live[$unsigned($random(seed)) % live.size()]);
				step();
			end
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((m_count != 0) || m_push) begin
			step();
			n++;
			if (n > LIMIT) begin
				fail_run("reorder buffer did not drain");
			end
		end
		step();
	endtask

	initial begin
		int prod;
		seed               = 32'ha806_e4f9;
		rst_i              = 1'b1;
		inst_valid_i       = 1'b0;
		inst_dest_i        = '0;
		inst_src_a_i       = '0;
		inst_src_b_i       = '0;
		iq_credit_i        = 1'b0;
		complete_valid_i   = 1'b0;
		complete_rob_idx_i = '0;
		complete_preg_i    = '0;
		auto_credit        = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		step();

		issue(5'd1, 5'd2, 5'd3);  // identity sources and dest tag 32
		issue(5'd2, 5'd4, 5'd1);
		prod = m_tail;
		issue(5'd5, 5'd0, 5'd0);
		issue(5'd6, 5'd5, 5'd5);  // producer still pending
		mark_complete(prod);
		issue(5'd7, 5'd5, 5'd6);  // forwarded in the completion cycle
		issue(5'd8, 5'd5, 5'd1);
		complete_shuffled();
		drain();

		// credit back-pressure
		auto_credit = 1'b0;
		step();
		for (int k = 0; k < CREDITS; k++) begin
			issue(rand_areg(), rand_areg(), rand_areg());
		end
		expect_stall(5'd9, 5'd1, 5'd2, 6);
		iq_credit_i = 1'b1;  // single slot back
		issue(5'd9, 5'd1, 5'd2);
		expect_stall(5'd10, 5'd9, 5'd9, 4);
		auto_credit = 1'b1;
		issue(5'd10, 5'd9, 5'd9);
		complete_shuffled();
		drain();

		// long random run that wraps the free pool
		for (int k = 0; k < 40; k++) begin
			issue(rand_areg(), rand_areg(), rand_areg());
			if (m_count >= 6) begin
				complete_shuffled();
			end
		end
		issue(ZERO_REG, 5'd3, 5'd4);  // no tag taken
		issue(5'd11, ZERO_REG, 5'd11);
		complete_shuffled();
		drain();

		// fill the rob with completions held back
		for (int k = 0; k < DEPTH; k++) begin
			issue(rand_areg(), rand_areg(), rand_areg());
		end
		expect_stall(5'd12, 5'd1, 5'd2, 5);
		mark_complete(m_head);
		issue(5'd12, 5'd1, 5'd2);
		complete_shuffled();
		drain();

		$display("Everything OK");
		$finish;
	end

endmodule : tb_rename_core

// ==== rename_core.sv ====
// rename core top level joining map table, free list, rob and dispatch
`timescale 1ns/1ps

module rename_core #(
	parameter int PREG_COUNT = rename_pkg::PREG_COUNT_DEF,
	parameter int ROB_DEPTH  = rename_pkg::ROB_DEPTH_DEF,
	parameter int IQ_CREDITS = rename_pkg::IQ_CREDITS_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,

	// decoded instruction in
	input  logic                          inst_valid_i,
	input  rename_pkg::arch_reg_t         inst_dest_i,
	input  rename_pkg::arch_reg_t         inst_src_a_i,
	input  rename_pkg::arch_reg_t         inst_src_b_i,
	output logic                          inst_accept_o,

	// issue queue, credit based
	input  logic                          iq_credit_i,
	output logic                          iq_valid_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_dest_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_old_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_src_a_preg_o,
	output logic                          iq_src_a_rdy_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_src_b_preg_o,
	output logic                          iq_src_b_rdy_o,
	output logic [$clog2(ROB_DEPTH)-1:0]  iq_rob_idx_o,

	// completion broadcast
	input  logic                          complete_valid_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]  complete_rob_idx_i,
	input  logic [$clog2(PREG_COUNT)-1:0] complete_preg_i,

	// committed mapping
	output logic                          retire_valid_o,
	output rename_pkg::arch_reg_t         retire_areg_o,
	output logic [$clog2(PREG_COUNT)-1:0] retire_preg_o
);
	localparam int TAG_W = $clog2(PREG_COUNT);
	localparam int IDX_W = $clog2(ROB_DEPTH);

	logic             alloc_has_dest;  // accept with real dest
	logic [TAG_W-1:0] fl_head_preg;    // tnew
	logic             fl_empty;
	logic [TAG_W-1:0] map_src_a_preg;
	logic [TAG_W-1:0] map_src_b_preg;
	logic [TAG_W-1:0] map_old_preg;    // told
	logic             map_src_a_rdy;
	logic             map_src_b_rdy;
	logic [IDX_W-1:0] rob_tail_idx;
	logic             rob_full;
	logic             rob_free_valid;
	logic [TAG_W-1:0] rob_free_preg;

	// ==============================
	// map table and free list
	// ==============================
	rename_map #(.PREG_COUNT(PREG_COUNT)) i_rename_map (
		.clk              (clk),
		.rst_i            (rst_i),
		.alloc_i          (inst_accept_o),
		.alloc_has_dest_i (alloc_has_dest),
		.dest_areg_i      (inst_dest_i),
		.src_a_areg_i     (inst_src_a_i),
		.src_b_areg_i     (inst_src_b_i),
		.new_preg_i       (fl_head_preg),
		.complete_valid_i (complete_valid_i),
		.complete_preg_i  (complete_preg_i),
		.src_a_preg_o     (map_src_a_preg),
		.src_b_preg_o     (map_src_b_preg),
		.old_preg_o       (map_old_preg),
		.src_a_rdy_o      (map_src_a_rdy),
		.src_b_rdy_o      (map_src_b_rdy)
	);

	free_list #(.PREG_COUNT(PREG_COUNT)) i_free_list (
		.clk         (clk),
		.rst_i       (rst_i),
		.pop_i       (alloc_has_dest),
		.push_i      (rob_free_valid),   // told from retire
		.push_preg_i (rob_free_preg),
		.head_preg_o (fl_head_preg),
		.empty_o     (fl_empty)
	);

	// ==============================
	// reorder buffer
	// ==============================
	rob #(
		.PREG_COUNT (PREG_COUNT),
		.ROB_DEPTH  (ROB_DEPTH)
	) i_rob (
		.clk                (clk),
		.rst_i              (rst_i),
		.alloc_i            (inst_accept_o),
		.alloc_has_dest_i   (alloc_has_dest),
		.alloc_areg_i       (inst_dest_i),
		.alloc_new_preg_i   (fl_head_preg),
		.alloc_old_preg_i   (map_old_preg),
		.complete_valid_i   (complete_valid_i),
		.complete_rob_idx_i (complete_rob_idx_i),
		.tail_idx_o         (rob_tail_idx),
		.full_o             (rob_full),
		.retire_valid_o     (retire_valid_o),
		.retire_areg_o      (retire_areg_o),
		.retire_preg_o      (retire_preg_o),
		.free_valid_o       (rob_free_valid),
		.free_preg_o        (rob_free_preg)
	);

	// ==============================
	// dispatch
	// ==============================
	rename_dispatch #(
		.PREG_COUNT (PREG_COUNT),
		.ROB_DEPTH  (ROB_DEPTH),
		.IQ_CREDITS (IQ_CREDITS)
	) i_rename_dispatch (
		.clk              (clk),
		.rst_i            (rst_i),
		.inst_valid_i     (inst_valid_i),
		.inst_dest_i      (inst_dest_i),
		.free_empty_i     (fl_empty),
		.rob_full_i       (rob_full),
		.free_preg_i      (fl_head_preg),
		.src_a_preg_i     (map_src_a_preg),
		.src_b_preg_i     (map_src_b_preg),
		.old_preg_i       (map_old_preg),
		.src_a_rdy_i      (map_src_a_rdy),
		.src_b_rdy_i      (map_src_b_rdy),
		.rob_idx_i        (rob_tail_idx),
		.iq_credit_i      (iq_credit_i),
		.inst_accept_o    (inst_accept_o),
		.alloc_has_dest_o (alloc_has_dest),
		.iq_valid_o       (iq_valid_o),
		.iq_dest_preg_o   (iq_dest_preg_o),
		.iq_old_preg_o    (iq_old_preg_o),
		.iq_src_a_preg_o  (iq_src_a_preg_o),
		.iq_src_a_rdy_o   (iq_src_a_rdy_o),
		.iq_src_b_preg_o  (iq_src_b_preg_o),
		.iq_src_b_rdy_o   (iq_src_b_rdy_o),
		.iq_rob_idx_o     (iq_rob_idx_o)
	);

endmodule : rename_core

// ==== rename_dispatch.sv ====
// dispatch decision, issue queue credit counter and registered iq output
`timescale 1ns/1ps

module rename_dispatch #(
	parameter int PREG_COUNT = rename_pkg::PREG_COUNT_DEF,
	parameter int ROB_DEPTH  = rename_pkg::ROB_DEPTH_DEF,
	parameter int IQ_CREDITS = rename_pkg::IQ_CREDITS_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,

	input  logic                          inst_valid_i,
	input  rename_pkg::arch_reg_t         inst_dest_i,

	input  logic                          free_empty_i,   // free list
	input  logic                          rob_full_i,     // rob
	input  logic [$clog2(PREG_COUNT)-1:0] free_preg_i,
	input  logic [$clog2(PREG_COUNT)-1:0] src_a_preg_i,   // map table
	input  logic [$clog2(PREG_COUNT)-1:0] src_b_preg_i,
	input  logic [$clog2(PREG_COUNT)-1:0] old_preg_i,
	input  logic                          src_a_rdy_i,
	input  logic                          src_b_rdy_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]  rob_idx_i,
	input  logic                          iq_credit_i,    // one slot back

	output logic                          inst_accept_o,  // also the alloc strobe
	output logic                          alloc_has_dest_o,

	output logic                          iq_valid_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_dest_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_old_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_src_a_preg_o,
	output logic                          iq_src_a_rdy_o,
	output logic [$clog2(PREG_COUNT)-1:0] iq_src_b_preg_o,
	output logic                          iq_src_b_rdy_o,
	output logic [$clog2(ROB_DEPTH)-1:0]  iq_rob_idx_o
);
	import rename_pkg::*;

	localparam int CRD_W = $clog2(IQ_CREDITS + 1);

	logic             has_dest;
	logic             credit_ok;
	logic [CRD_W-1:0] credit_q;  // free iq slots

	// ==============================
	// stall decision
	// ==============================
	assign has_dest  = (inst_dest_i != ZERO_REG);
	assign credit_ok = (credit_q != '0);

	// zero reg dest needs no free tag
	assign inst_accept_o = inst_valid_i && credit_ok && !rob_full_i &&
		(!free_empty_i || !has_dest);
	assign alloc_has_dest_o = inst_accept_o && has_dest;  // pops the free list

	// credit spent at accept, returned by the iq
	always_ff @(posedge clk) begin
		if (rst_i) begin
			credit_q <= CRD_W'(IQ_CREDITS);
		end else begin
			case ({inst_accept_o, iq_credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	// ==============================
	// iq output register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			iq_valid_o <= 1'b0;
		end else begin
			iq_valid_o <= inst_accept_o;  // one pulse per accept
		end
	end

	always_ff @(posedge clk) begin
		if (inst_accept_o) begin
			iq_dest_preg_o  <= has_dest ? free_preg_i : '0;
			iq_old_preg_o   <= old_preg_i;
			iq_src_a_preg_o <= src_a_preg_i;
			iq_src_a_rdy_o  <= src_a_rdy_i;
			iq_src_b_preg_o <= src_b_preg_i;
			iq_src_b_rdy_o  <= src_b_rdy_i;
			iq_rob_idx_o    <= rob_idx_i;
		end
	end

	// iq never returns more credits than it was given
	a_credit_range: assert property (@(posedge clk) disable iff (rst_i)
		credit_q <= CRD_W'(IQ_CREDITS))
		else $error("iq credit count above limit");

endmodule : rename_dispatch

// ==== rob.sv ====
// reorder buffer with old tags, completion marking and in-order retirement
`timescale 1ns/1ps

module rob #(
	parameter int PREG_COUNT = rename_pkg::PREG_COUNT_DEF,
	parameter int ROB_DEPTH  = rename_pkg::ROB_DEPTH_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,

	input  logic                          alloc_i,
	input  logic                          alloc_has_dest_i,
	input  rename_pkg::arch_reg_t         alloc_areg_i,
	input  logic [$clog2(PREG_COUNT)-1:0] alloc_new_preg_i,  // tnew
	input  logic [$clog2(PREG_COUNT)-1:0] alloc_old_preg_i,  // told

	input  logic                          complete_valid_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]  complete_rob_idx_i,

	output logic [$clog2(ROB_DEPTH)-1:0]  tail_idx_o,        // idx for next dispatch
	output logic                          full_o,

	output logic                          retire_valid_o,
	output rename_pkg::arch_reg_t         retire_areg_o,
	output logic [$clog2(PREG_COUNT)-1:0] retire_preg_o,
	output logic                          free_valid_o,      // told back to free list
	output logic [$clog2(PREG_COUNT)-1:0] free_preg_o
);
	import rename_pkg::*;

	localparam int TAG_W = $clog2(PREG_COUNT);
	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = IDX_W + 1;

	// entry fields
	arch_reg_t            areg_q     [ROB_DEPTH];
	logic [TAG_W-1:0]     new_preg_q [ROB_DEPTH];
	logic [TAG_W-1:0]     old_preg_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] has_dest_q;
	logic [ROB_DEPTH-1:0] done_q;

	logic [IDX_W-1:0] head_q;
	logic [IDX_W-1:0] tail_q;
	logic [CNT_W-1:0] count_q;
	logic             retire_now;  // head done this cycle
	logic [IDX_W-1:0] comp_ofs;    // completing entry's distance from head

	assign tail_idx_o = tail_q;
	assign full_o     = (count_q == CNT_W'(ROB_DEPTH));
	assign retire_now = (count_q != '0) && done_q[head_q];
	assign comp_ofs   = complete_rob_idx_i - head_q;

	// ==============================
	// entry storage
	// ==============================
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			areg_q[tail_q]     <= alloc_areg_i;
			new_preg_q[tail_q] <= alloc_new_preg_i;
			old_preg_q[tail_q] <= alloc_old_preg_i;
			has_dest_q[tail_q] <= alloc_has_dest_i;
			done_q[tail_q]     <= 1'b0;  // fresh entry
		end
		if (complete_valid_i) begin
			done_q[complete_rob_idx_i] <= 1'b1;
		end
	end

	// ==============================
	// pointers and retire strobe
	// ==============================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			head_q         <= '0;
			tail_q         <= '0;
			count_q        <= '0;
			retire_valid_o <= 1'b0;
			free_valid_o   <= 1'b0;
		end else begin
			if (alloc_i) begin
				tail_q <= tail_q + 1'b1;
			end
			if (retire_now) begin
				head_q <= head_q + 1'b1;
			end
			case ({alloc_i, retire_now})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			retire_valid_o <= retire_now;
			free_valid_o   <= retire_now && has_dest_q[head_q];  // zero reg frees nothing
		end
	end

	// retiring entry payload
	always_ff @(posedge clk) begin
		if (retire_now) begin
			retire_areg_o <= areg_q[head_q];
			retire_preg_o <= has_dest_q[head_q] ? new_preg_q[head_q] : '0;
			free_preg_o   <= old_preg_q[head_q];
		end
	end

	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst_i)
		alloc_i |-> !full_o)
		else $error("rob alloc while full");

	// completion must hit a dispatched entry that is still pending
	a_comp_live: assert property (@(posedge clk) disable iff (rst_i)
		complete_valid_i |-> ((CNT_W'(comp_ofs) < count_q) && !done_q[complete_rob_idx_i]))
		else $error("completion to dead or done rob entry");

endmodule : rob

// ==== free_list.sv ====
// free list as a circular queue of free physical register tags
`timescale 1ns/1ps

module free_list #(
	parameter int PREG_COUNT = rename_pkg::PREG_COUNT_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,

	input  logic                          pop_i,        // dispatch with dest
	input  logic                          push_i,       // told from rob retire
	input  logic [$clog2(PREG_COUNT)-1:0] push_preg_i,

	output logic [$clog2(PREG_COUNT)-1:0] head_preg_o,  // next tnew
	output logic                          empty_o
);
	import rename_pkg::*;

	localparam int TAG_W   = $clog2(PREG_COUNT);
	localparam int CNT_W   = TAG_W + 1;
	localparam int FL_INIT = PREG_COUNT - NUM_AREGS;  // tags above the aregs

	logic [TAG_W-1:0] fifo_q [PREG_COUNT];  // tag storage
	logic [TAG_W-1:0] head_q;
	logic [TAG_W-1:0] tail_q;
	logic [CNT_W-1:0] count_q;

	assign head_preg_o = fifo_q[head_q];
	assign empty_o     = (count_q == '0);

	// ==============================
	// queue state
	// ==============================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			// preload in ascending order
			for (int i = 0; i < FL_INIT; i++) begin
				fifo_q[i] <= TAG_W'(NUM_AREGS + i);
			end
			head_q  <= '0;
			tail_q  <= TAG_W'(FL_INIT);
			count_q <= CNT_W'(FL_INIT);
		end else begin
			if (pop_i) begin
				head_q <= head_q + 1'b1;
			end
			if (push_i) begin
				fifo_q[tail_q] <= push_preg_i;  // poppable next cycle
				tail_q         <= tail_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;   // both or neither
			endcase
		end
	end

	// dispatch must see empty before popping
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("free list popped while empty");

	// more free tags than non-arch pregs means a double free upstream
	a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
		push_i |-> (count_q < CNT_W'(FL_INIT)))
		else $error("free list pushed while full");

endmodule : free_list

// ==== rename_map.sv ====
// rename map table from areg to preg plus per-preg ready bits
`timescale 1ns/1ps

module rename_map #(
	parameter int PREG_COUNT = rename_pkg::PREG_COUNT_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,

	input  logic                          alloc_i,          // dispatch fires
	input  logic                          alloc_has_dest_i, // dest is a real reg
	input  rename_pkg::arch_reg_t         dest_areg_i,
	input  rename_pkg::arch_reg_t         src_a_areg_i,
	input  rename_pkg::arch_reg_t         src_b_areg_i,
	input  logic [$clog2(PREG_COUNT)-1:0] new_preg_i,       // tnew from free list head

	input  logic                          complete_valid_i, // completion broadcast
	input  logic [$clog2(PREG_COUNT)-1:0] complete_preg_i,

	output logic [$clog2(PREG_COUNT)-1:0] src_a_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] src_b_preg_o,
	output logic [$clog2(PREG_COUNT)-1:0] old_preg_o,       // told to rob
	output logic                          src_a_rdy_o,
	output logic                          src_b_rdy_o
);
	import rename_pkg::*;

	localparam int TAG_W = $clog2(PREG_COUNT);

	logic [TAG_W-1:0]      map_q [NUM_AREGS]; // speculative map
	logic [PREG_COUNT-1:0] ready_q;           // one bit per preg

	// ==============================
	// lookups
	// ==============================
	assign src_a_preg_o = map_q[src_a_areg_i];
	assign src_b_preg_o = map_q[src_b_areg_i];
	assign old_preg_o   = map_q[dest_areg_i];  // read before the new write lands

	// completion in this cycle already counts as ready
	assign src_a_rdy_o = ready_q[src_a_preg_o] |
		(complete_valid_i && (complete_preg_i == src_a_preg_o));
	assign src_b_rdy_o = ready_q[src_b_preg_o] |
		(complete_valid_i && (complete_preg_i == src_b_preg_o));

	// ==============================
	// table update
	// ==============================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int r = 0; r < NUM_AREGS; r++) begin
				map_q[r] <= TAG_W'(r);  // identity map
			end
			ready_q <= '1;              // arch values all present
		end else begin
			if (complete_valid_i) begin
				ready_q[complete_preg_i] <= 1'b1;
			end
			if (alloc_i && alloc_has_dest_i) begin
				map_q[dest_areg_i]  <= new_preg_i;
				ready_q[new_preg_i] <= 1'b0;  // producer not done yet
			end
		end
	end

	// zero reg is never a dest so its preg stays ready forever
	a_zero_rdy: assert property (@(posedge clk) disable iff (rst_i)
		ready_q[map_q[ZERO_REG]])
		else $error("ready bit of zero reg mapping cleared");

endmodule : rename_map

// ==== rename_pkg.sv ====
// rename package with architectural register type, zero register and default sizes
package rename_pkg;

	// ==============================
	// architectural register file
	// ==============================
	localparam int NUM_AREGS = 32;           // integer aregs seen by decode

	typedef logic [4:0] arch_reg_t;          // areg index

	localparam arch_reg_t ZERO_REG = 5'd31;  // hardwired zero, never renamed

	// ==============================
	// default sizes
	// ==============================
	// all powers of two with preg count above NUM_AREGS
	localparam int PREG_COUNT_DEF = 64;      // physical regs
	localparam int ROB_DEPTH_DEF  = 16;      // rob entries
	localparam int IQ_CREDITS_DEF = 4;       // iq slots granted after reset

endpackage : rename_pkg
